// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module vector_decode_stage_tb \
  -f vector_decode_stage.f \
  -Mdir obj_dir

sim_out=$(./obj_dir/Vvector_decode_stage_tb)
echo "$sim_out"
echo "$sim_out" | grep -q "SIMULATION PASSED"

// File: source/decode_execute_reg.sv
`timescale 1ns/1ns
`default_nettype none

module decode_execute_reg
  import vdecode_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic             flush,
  input  logic             stall,
  input  logic             de_en,
  element_if.user          elem,
  write_slot_if.regs       slot,
  input  logic             mask0,
  input  logic             mask1,
  input  logic [XLEN-1:0]  imm,
  input  logic [XLEN-1:0]  vs1_data0,
  input  logic [XLEN-1:0]  vs1_data1,
  input  logic [XLEN-1:0]  vs2_data0,
  input  logic [XLEN-1:0]  vs2_data1,
  output logic             ex_valid,
  output logic             ex_last,
  output logic             ex_wen0,
  output logic             ex_wen1,
  output logic             ex_mask0,
  output logic             ex_mask1,
  output offset_t          ex_woffset0,
  output offset_t          ex_woffset1,
  output sew_t             ex_eew,
  output logic [XLEN-1:0]  ex_imm,
  output logic [XLEN-1:0]  ex_vs1_lane0,
  output logic [XLEN-1:0]  ex_vs1_lane1,
  output logic [XLEN-1:0]  ex_vs2_lane0,
  output logic [XLEN-1:0]  ex_vs2_lane1
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_valid     <= 1'b0;
      ex_last      <= 1'b0;
      ex_wen0      <= 1'b0;
      ex_wen1      <= 1'b0;
      ex_mask0     <= 1'b0;
      ex_mask1     <= 1'b0;
      ex_woffset0  <= '0;
      ex_woffset1  <= '0;
      ex_eew       <= SEW8;
      ex_imm       <= '0;
      ex_vs1_lane0 <= '0;
      ex_vs1_lane1 <= '0;
      ex_vs2_lane0 <= '0;
      ex_vs2_lane1 <= '0;
    end else if (flush) begin  // beats stall and sends a bubble to execute
      ex_valid     <= 1'b0;
      ex_last      <= 1'b0;
      ex_wen0      <= 1'b0;
      ex_wen1      <= 1'b0;
      ex_mask0     <= 1'b0;
      ex_mask1     <= 1'b0;
      ex_woffset0  <= '0;
      ex_woffset1  <= '0;
      ex_eew       <= SEW8;
      ex_imm       <= '0;
      ex_vs1_lane0 <= '0;
      ex_vs1_lane1 <= '0;
      ex_vs2_lane0 <= '0;
      ex_vs2_lane1 <= '0;
    end else if (!stall) begin
      ex_valid     <= de_en;
      ex_last      <= elem.done;
      ex_wen0      <= slot.wen0;
      ex_wen1      <= slot.wen1;
      ex_mask0     <= mask0;
      ex_mask1     <= mask1;
      ex_woffset0  <= slot.woffset0;
      ex_woffset1  <= slot.woffset1;
      ex_eew       <= slot.eew;
      ex_imm       <= imm;
      ex_vs1_lane0 <= vs1_data0;  // rf data lines up with this cycle's offsets
      ex_vs1_lane1 <= vs1_data1;
      ex_vs2_lane0 <= vs2_data0;
      ex_vs2_lane1 <= vs2_data1;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST) flush |=> !ex_valid)
    else $error("ex_valid set in the cycle after a flush");

endmodule

`default_nettype wire

// File: source/element_counter.sv
`timescale 1ns/1ns
`default_nettype none

module element_counter
  import vdecode_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      de_en,
  input  logic      stall,
  input  logic      flush,
  input  offset_t   vstart,
  input  offset_t   vl,
  element_if.counter elem
);

  offset_t                offset;
  logic [ELEM_OFFSET_W:0] next_pair;  // one extra bit so vl near the top still compares

  assign next_pair = {1'b0, offset} + (ELEM_OFFSET_W+1)'(LANES);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset <= '0;
    end else if (!de_en || flush) begin
      offset <= vstart;  // idle or squashed, park at vstart
    end else if (!stall) begin
      if (elem.done) begin
        offset <= vstart;  // ready for the next instruction
      end else begin
        offset <= next_pair[ELEM_OFFSET_W-1:0];
      end
    end
  end

  assign elem.offset = offset;
  assign elem.done   = next_pair >= {1'b0, vl};
  assign elem.busy   = de_en & ~elem.done;

  // a busy walk never runs more than one pair past vl, even across stalls and flushes
  assert property (@(posedge CLK) disable iff (!nRST)
    elem.busy |=> ({1'b0, offset} < {1'b0, $past(vl)} + (ELEM_OFFSET_W+1)'(LANES)))
    else $error("element offset %0d ran past vl %0d", offset, $past(vl));

endmodule

`default_nettype wire

// File: source/element_if.sv
`timescale 1ns/1ns
`default_nettype none

interface element_if
  import vdecode_pkg::*;
();

  offset_t offset;  // first element of the current lane pair
  logic    done;    // last pair of the instruction
  logic    busy;

  modport counter (output offset, done, busy);

  modport user (input offset, done, busy);

endinterface

`default_nettype wire

// File: source/operand_offset_gen.sv
`timescale 1ns/1ns
`default_nettype none

module operand_offset_gen
  import vdecode_pkg::*;
(
  element_if.user          elem,
  input  vs1_src_t         vs1_src,
  input  vs2_src_t         vs2_src,
  input  sew_t             sew,
  input  logic             vs2_widen,
  input  logic [XLEN-1:0]  xs1,
  input  logic [IMM_W-1:0] imm5,
  input  logic             is_signed,
  input  logic [XLEN-1:0]  vs1_data0,
  input  logic [XLEN-1:0]  vs1_data1,
  input  logic [LANES-1:0] vs1_mask,
  input  logic [LANES-1:0] vs2_mask,
  output offset_t          vs1_offset,
  output offset_t          vs2_offset,
  output sew_t             vs2_sew,
  output logic             mask0,
  output logic             mask1,
  output logic [XLEN-1:0]  imm
);

  offset_t [LANES-1:0] vs1_pair;  // lane 1 only matters inside the pair read
  offset_t [LANES-1:0] vs2_pair;
  offset_t             uimm;
  offset_t             rs1;

  assign uimm = offset_t'(imm5);  // zero extended
  assign rs1  = xs1[ELEM_OFFSET_W-1:0];

  always_comb begin
    unique case (vs1_src)
      VS1_ZERO: vs1_pair = '0;
      default: begin
        vs1_pair[0] = elem.offset;
        vs1_pair[1] = elem.offset + 8'd1;
      end
    endcase
  end

  always_comb begin
    unique case (vs2_src)
      VS2_NORMAL: begin
        vs2_pair[0] = elem.offset;
        vs2_pair[1] = elem.offset + 8'd1;
      end
      VS2_IDX_PLUS_RS1: begin
        vs2_pair[0] = elem.offset + rs1;
        vs2_pair[1] = elem.offset + rs1 + 8'd1;
      end
      VS2_IDX_PLUS_UIMM: begin
        vs2_pair[0] = elem.offset + uimm;
        vs2_pair[1] = elem.offset + uimm + 8'd1;
      end
      VS2_IDX_PLUS_1: begin  // slide down by one
        vs2_pair[0] = elem.offset + 8'd1;
        vs2_pair[1] = elem.offset + 8'd2;
      end
      VS2_VS1: begin
        vs2_pair[0] = vs1_data0[ELEM_OFFSET_W-1:0];
        vs2_pair[1] = vs1_data1[ELEM_OFFSET_W-1:0];
      end
      VS2_RS1:  vs2_pair = {rs1, rs1};
      VS2_UIMM: vs2_pair = {uimm, uimm};
      default:  vs2_pair = '0;
    endcase
  end

  assign vs1_offset = vs1_pair[0];
  assign vs2_offset = vs2_pair[0];

  always_comb begin
    vs2_sew = widen_sew(sew, vs2_widen);
    assert (vs2_sew >= sew) else $error("vs2 width %0d narrower than sew %0d", vs2_sew, sew);
  end

  // vs1 mask first, vs2 next, vs1 again when neither walks normally
  always_comb begin
    if (vs1_src == VS1_NORMAL) begin
      {mask1, mask0} = vs1_mask;
    end else if (vs2_src == VS2_NORMAL) begin
      {mask1, mask0} = vs2_mask;
    end else begin
      {mask1, mask0} = vs1_mask;
    end
  end

  assign imm = is_signed ? {{(XLEN-IMM_W){imm5[IMM_W-1]}}, imm5}
                         : {{(XLEN-IMM_W){1'b0}}, imm5};

endmodule

`default_nettype wire

// File: source/vdecode_pkg.sv
`default_nettype none

package vdecode_pkg;

  localparam int ELEM_OFFSET_W = 8;
  localparam int XLEN          = 32;
  localparam int IMM_W         = 5;  // imm field of OPIVI forms
  localparam int LANES         = 2;  // elements handled per cycle

  typedef logic [ELEM_OFFSET_W-1:0] offset_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic {
    VS1_NORMAL = 1'b0,
    VS1_ZERO   = 1'b1
  } vs1_src_t;

  typedef enum logic [2:0] {
    VS2_NORMAL        = 3'd0,
    VS2_IDX_PLUS_RS1  = 3'd1,
    VS2_IDX_PLUS_UIMM = 3'd2,
    VS2_IDX_PLUS_1    = 3'd3,
    VS2_VS1           = 3'd4,  // gather style, offsets come from vs1 data
    VS2_RS1           = 3'd5,
    VS2_UIMM          = 3'd6,
    VS2_ZERO          = 3'd7
  } vs2_src_t;

  typedef enum logic [2:0] {
    VD_NORMAL        = 3'd0,
    VD_ZERO          = 3'd1,
    VD_IDX_PLUS_RS1  = 3'd2,
    VD_IDX_PLUS_UIMM = 3'd3,
    VD_IDX_PLUS_1    = 3'd4
  } vd_src_t;

  // double the element width, saturating at SEW32
  function automatic sew_t widen_sew(input sew_t sew, input logic widen);
    sew_t res;
    res = sew;
    if (widen) begin
      res = (sew == SEW8) ? SEW16 : SEW32;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: source/vector_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module vector_decode_stage
  import vdecode_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic             de_en,
  input  logic             stall,
  input  logic             flush,
  input  offset_t          vstart,
  input  offset_t          vl,
  input  vs1_src_t         vs1_src,
  input  vs2_src_t         vs2_src,
  input  vd_src_t          vd_src,
  input  sew_t             sew,
  input  logic             vs2_widen,
  input  logic             vd_widen,
  input  logic             wen,
  input  logic [XLEN-1:0]  xs1,
  input  logic [IMM_W-1:0] imm5,
  input  logic             is_signed,
  input  logic [XLEN-1:0]  vs1_data0,
  input  logic [XLEN-1:0]  vs1_data1,
  input  logic [XLEN-1:0]  vs2_data0,
  input  logic [XLEN-1:0]  vs2_data1,
  input  logic [LANES-1:0] vs1_mask,
  input  logic [LANES-1:0] vs2_mask,
  output offset_t          vs1_offset,  // to the vector register file
  output offset_t          vs2_offset,
  output sew_t             vs2_sew,
  output logic             ex_valid,
  output logic             ex_last,
  output logic             ex_wen0,
  output logic             ex_wen1,
  output logic             ex_mask0,
  output logic             ex_mask1,
  output offset_t          ex_woffset0,
  output offset_t          ex_woffset1,
  output sew_t             ex_eew,
  output logic [XLEN-1:0]  ex_imm,
  output logic [XLEN-1:0]  ex_vs1_lane0,
  output logic [XLEN-1:0]  ex_vs1_lane1,
  output logic [XLEN-1:0]  ex_vs2_lane0,
  output logic [XLEN-1:0]  ex_vs2_lane1
);

  logic            mask0;
  logic            mask1;
  logic [XLEN-1:0] imm;

  element_if    elem_if ();
  write_slot_if slot_if ();

  element_counter i_element_counter (
    .CLK, .nRST, .de_en, .stall, .flush, .vstart, .vl,
    .elem (elem_if.counter)
  );

  operand_offset_gen i_operand_offset_gen (
    .elem (elem_if.user),
    .vs1_src, .vs2_src, .sew, .vs2_widen, .xs1, .imm5, .is_signed,
    .vs1_data0, .vs1_data1, .vs1_mask, .vs2_mask,
    .vs1_offset, .vs2_offset, .vs2_sew, .mask0, .mask1, .imm
  );

  write_offset_gen i_write_offset_gen (
    .elem (elem_if.user),
    .vd_src, .sew, .vd_widen, .wen, .vl, .xs1, .imm5,
    .slot (slot_if.gen)
  );

  decode_execute_reg i_decode_execute_reg (
    .CLK, .nRST, .flush, .stall, .de_en,
    .elem (elem_if.user),
    .slot (slot_if.regs),
    .mask0, .mask1, .imm,
    .vs1_data0, .vs1_data1, .vs2_data0, .vs2_data1,
    .ex_valid, .ex_last, .ex_wen0, .ex_wen1, .ex_mask0, .ex_mask1,
    .ex_woffset0, .ex_woffset1, .ex_eew, .ex_imm,
    .ex_vs1_lane0, .ex_vs1_lane1, .ex_vs2_lane0, .ex_vs2_lane1
  );

endmodule

`default_nettype wire

// File: source/write_offset_gen.sv
`timescale 1ns/1ns
`default_nettype none

module write_offset_gen
  import vdecode_pkg::*;
(
  element_if.user          elem,
  input  vd_src_t          vd_src,
  input  sew_t             sew,
  input  logic             vd_widen,
  input  logic             wen,
  input  offset_t          vl,
  input  logic [XLEN-1:0]  xs1,
  input  logic [IMM_W-1:0] imm5,
  write_slot_if.gen        slot
);

  offset_t                uimm;
  offset_t                rs1;
  logic [ELEM_OFFSET_W:0] lane1_idx;  // widened so vl at max still works

  assign uimm = offset_t'(imm5);
  assign rs1  = xs1[ELEM_OFFSET_W-1:0];

  always_comb begin
    unique case (vd_src)
      VD_NORMAL: begin
        slot.woffset0 = elem.offset;
        slot.woffset1 = elem.offset + 8'd1;
      end
      VD_IDX_PLUS_RS1: begin  // slide up by rs1
        slot.woffset0 = elem.offset + rs1;
        slot.woffset1 = elem.offset + rs1 + 8'd1;
      end
      VD_IDX_PLUS_UIMM: begin
        slot.woffset0 = elem.offset + uimm;
        slot.woffset1 = elem.offset + uimm + 8'd1;
      end
      VD_IDX_PLUS_1: begin
        slot.woffset0 = elem.offset + 8'd1;
        slot.woffset1 = elem.offset + 8'd2;
      end
      default: begin  // VD_ZERO, scalar-move style writes
        slot.woffset0 = '0;
        slot.woffset1 = '0;
      end
    endcase
  end

  assign slot.eew = widen_sew(sew, vd_widen);

  // odd vl leaves lane 1 empty on the last pair
  assign lane1_idx = {1'b0, elem.offset} + 9'd1;
  assign slot.wen0 = wen;
  assign slot.wen1 = wen & (lane1_idx < {1'b0, vl});

endmodule

`default_nettype wire

// File: source/write_slot_if.sv
`timescale 1ns/1ns
`default_nettype none

interface write_slot_if
  import vdecode_pkg::*;
();

  offset_t woffset0;
  offset_t woffset1;
  logic    wen0;
  logic    wen1;
  sew_t    eew;  // width after widening

  modport gen (output woffset0, woffset1, wen0, wen1, eew);
  modport regs (input woffset0, woffset1, wen0, wen1, eew);

endinterface

`default_nettype wire

// File: vector_decode_stage.f
+incdir+verification
source/vdecode_pkg.sv
source/element_if.sv
source/write_slot_if.sv
source/element_counter.sv
source/operand_offset_gen.sv
source/write_offset_gen.sv
source/decode_execute_reg.sv
source/vector_decode_stage.sv
verification/vector_decode_stage_tb.sv

// File: verification/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

import vdecode_pkg::*;

// lane 0 read offset for vs1
function automatic offset_t model_vs1_offset(vs1_src_t src, offset_t idx);
  return (src == VS1_ZERO) ? 8'd0 : idx;
endfunction

// lane 0 read offset for vs2, gather uses the low byte of vs1 lane 0
function automatic offset_t model_vs2_offset(vs2_src_t src, offset_t idx, logic [XLEN-1:0] rs1,
                                            logic [IMM_W-1:0] uimm, logic [XLEN-1:0] gather);
  case (src)
    VS2_NORMAL:        return idx;
    VS2_IDX_PLUS_RS1:  return idx + rs1[7:0];
    VS2_IDX_PLUS_UIMM: return idx + {3'b000, uimm};
    VS2_IDX_PLUS_1:    return idx + 8'd1;
    VS2_VS1:           return gather[7:0];
    VS2_RS1:           return rs1[7:0];
    VS2_UIMM:          return {3'b000, uimm};
    default:           return 8'd0;
  endcase
endfunction

// destination offset of one lane
function automatic offset_t model_vd_offset(vd_src_t src, offset_t idx, logic [XLEN-1:0] rs1,
                                           logic [IMM_W-1:0] uimm, logic lane);
  offset_t step;
  step = {7'd0, lane};
  case (src)
    VD_NORMAL:        return idx + step;
    VD_IDX_PLUS_RS1:  return idx + rs1[7:0] + step;
    VD_IDX_PLUS_UIMM: return idx + {3'b000, uimm} + step;
    VD_IDX_PLUS_1:    return idx + 8'd1 + step;
    default:          return 8'd0;  // zero source, same for both lanes
  endcase
endfunction

function automatic sew_t model_widen(sew_t sew, logic widen);
  if (!widen) return sew;
  if (sew == SEW8) return SEW16;
  return SEW32;  // 16 doubles to 32, 32 saturates
endfunction

// {lane 1, lane 0}
function automatic logic [1:0] model_mask(vs1_src_t s1, vs2_src_t s2, logic [1:0] m1,
                                          logic [1:0] m2);
  if (s1 != VS1_NORMAL && s2 == VS2_NORMAL) return m2;
  return m1;
endfunction

function automatic logic [XLEN-1:0] model_imm(logic [IMM_W-1:0] imm5, logic sgn);
  return sgn ? XLEN'($signed(imm5)) : XLEN'(imm5);
endfunction

function automatic logic model_done(offset_t idx, offset_t vl);
  return (9'(idx) + 9'd2) >= 9'(vl);
endfunction

function automatic logic model_wen1(logic wen, offset_t idx, offset_t vl);
  return wen && ((9'(idx) + 9'd1) < 9'(vl));
endfunction

`endif

// File: verification/vector_decode_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_model.svh"

module vector_decode_stage_tb
  import vdecode_pkg::*;
();

  localparam int NUM_TESTS = 200;

  logic CLK, nRST, de_en, stall, flush, vs2_widen, vd_widen, wen, is_signed;
  offset_t vstart, vl, vs1_offset, vs2_offset, ex_woffset0, ex_woffset1;
  vs1_src_t vs1_src;
  vs2_src_t vs2_src;
  vd_src_t vd_src;
  sew_t sew, vs2_sew, ex_eew;
  logic [XLEN-1:0] xs1, vs1_data0, vs1_data1, vs2_data0, vs2_data1, ex_imm;
  logic [XLEN-1:0] ex_vs1_lane0, ex_vs1_lane1, ex_vs2_lane0, ex_vs2_lane1;
  logic [IMM_W-1:0] imm5;
  logic [LANES-1:0] vs1_mask, vs2_mask;
  logic ex_valid, ex_last, ex_wen0, ex_wen1, ex_mask0, ex_mask1;

  typedef struct packed {
    logic valid, last, wen0, wen1, mask0, mask1;
    offset_t woff0, woff1;
    sew_t eew;
    logic [XLEN-1:0] imm, vs1_0, vs1_1, vs2_0, vs2_1;
  } ex_bundle_t;

  ex_bundle_t exp_ex;   // what execute should see now
  offset_t    m_offset; // model copy of the element counter
  int n_errors, n_checks, test_idx;

  vector_decode_stage i_dut (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // register file contents, a fixed function of bank and offset
  function automatic logic [XLEN-1:0] rf_word(logic [1:0] bank, offset_t idx);
    return {bank, 6'h2b, ~idx, idx, idx ^ 8'h3c};
  endfunction

  function automatic logic [1:0] rf_mask(logic bank, offset_t idx);
    offset_t nxt;
    nxt = idx + 8'd1;
    return {^nxt[2:0] ^ bank, ^idx[2:0] ^ bank};
  endfunction

  always_comb begin
    vs1_data0 = rf_word(2'd1, vs1_offset);
    vs1_data1 = rf_word(2'd1, vs1_offset + 8'd1);
    vs1_mask  = rf_mask(1'b0, vs1_offset);
  end

  always_comb begin  // separate block, vs2 offset may depend on vs1 data
    vs2_data0 = rf_word(2'd2, vs2_offset);
    vs2_data1 = rf_word(2'd2, vs2_offset + 8'd1);
    vs2_mask  = rf_mask(1'b1, vs2_offset);
  end

  always @(posedge CLK, negedge nRST) begin : ref_model
    offset_t    vs1_off;
    offset_t    vs2_off;
    logic       done;
    logic [1:0] masks;
    vs1_off = model_vs1_offset(vs1_src, m_offset);
    vs2_off = model_vs2_offset(vs2_src, m_offset, xs1, imm5, rf_word(2'd1, vs1_off));
    done    = model_done(m_offset, vl);
    masks   = model_mask(vs1_src, vs2_src, rf_mask(1'b0, vs1_off), rf_mask(1'b1, vs2_off));
    if (!nRST) begin
      m_offset <= '0;
      exp_ex   <= '0;
    end else begin
      if (!de_en || flush) m_offset <= vstart;
      else if (!stall) m_offset <= done ? vstart : m_offset + 8'd2;
      if (flush) begin
        exp_ex <= '0;  // bubble
      end else if (!stall) begin
        exp_ex <= '{de_en, done, wen, model_wen1(wen, m_offset, vl), masks[0], masks[1],
                    model_vd_offset(vd_src, m_offset, xs1, imm5, 1'b0),
                    model_vd_offset(vd_src, m_offset, xs1, imm5, 1'b1),
                    model_widen(sew, vd_widen), model_imm(imm5, is_signed),
                    rf_word(2'd1, vs1_off), rf_word(2'd1, vs1_off + 8'd1),
                    rf_word(2'd2, vs2_off), rf_word(2'd2, vs2_off + 8'd1)};
      end
    end
  end

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    n_checks++;
    if (act_val !== exp_val) begin
      n_errors++;
      $display("** Error %s (test %0d): expected %0h, actual %0h", name, test_idx, exp_val,
               act_val);
    end
  endtask

  task automatic check_outputs();
    offset_t vs1_exp;
    offset_t vs2_exp;
    vs1_exp = model_vs1_offset(vs1_src, m_offset);
    vs2_exp = model_vs2_offset(vs2_src, m_offset, xs1, imm5, rf_word(2'd1, vs1_exp));
    compare_value("vs1_offset", 32'(vs1_exp), 32'(vs1_offset));
    compare_value("vs2_offset", 32'(vs2_exp), 32'(vs2_offset));
    compare_value("vs2_sew", 32'(model_widen(sew, vs2_widen)), 32'(vs2_sew));
    compare_value("ex_valid", 32'(exp_ex.valid), 32'(ex_valid));
    compare_value("ex_last", 32'(exp_ex.last), 32'(ex_last));
    compare_value("ex_wen0", 32'(exp_ex.wen0), 32'(ex_wen0));
    compare_value("ex_wen1", 32'(exp_ex.wen1), 32'(ex_wen1));
    compare_value("ex_mask0", 32'(exp_ex.mask0), 32'(ex_mask0));
    compare_value("ex_mask1", 32'(exp_ex.mask1), 32'(ex_mask1));
    compare_value("ex_woffset0", 32'(exp_ex.woff0), 32'(ex_woffset0));
    compare_value("ex_woffset1", 32'(exp_ex.woff1), 32'(ex_woffset1));
    compare_value("ex_eew", 32'(exp_ex.eew), 32'(ex_eew));
    compare_value("ex_imm", exp_ex.imm, ex_imm);
    compare_value("ex_vs1_lane0", exp_ex.vs1_0, ex_vs1_lane0);
    compare_value("ex_vs1_lane1", exp_ex.vs1_1, ex_vs1_lane1);
    compare_value("ex_vs2_lane0", exp_ex.vs2_0, ex_vs2_lane0);
    compare_value("ex_vs2_lane1", exp_ex.vs2_1, ex_vs2_lane1);
  endtask

  task automatic pick_instruction();
    vl        = 8'($urandom_range(1, 32));
    vstart    = 8'($urandom_range(0, int'(vl) - 1));
    vs1_src   = vs1_src_t'(1'($urandom_range(0, 1)));
    vs2_src   = vs2_src_t'(3'($urandom_range(0, 7)));
    vd_src    = vd_src_t'(3'($urandom_range(0, 4)));
    sew       = sew_t'(2'($urandom_range(0, 2)));
    vs2_widen = 1'($urandom_range(0, 1));
    vd_widen  = 1'($urandom_range(0, 1));
    wen       = 1'($urandom_range(0, 1));
    is_signed = 1'($urandom_range(0, 1));
    xs1       = 32'($urandom_range(0, 15));
    imm5      = 5'($urandom);
  endtask

  // one instruction from vstart until the last pair leaves decode
  task automatic run_instruction();
    logic finished;
    pick_instruction();
    de_en = 1'b0;  // idle cycle parks the counter at the new vstart
    stall = 1'b0;
    flush = 1'b0;
    @(negedge CLK);
    check_outputs();
    de_en    = 1'b1;
    finished = 1'b0;
    while (!finished) begin
      stall    = ($urandom_range(0, 4) == 0);
      flush    = ($urandom_range(0, 31) == 0);
      finished = !stall && !flush && model_done(m_offset, vl);
      @(negedge CLK);
      check_outputs();
    end
    de_en = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h312f9573));
    n_errors = 0;
    n_checks = 0;
    test_idx = 0;
    nRST     = 1'b0;
    de_en    = 1'b0;
    stall    = 1'b0;
    flush    = 1'b0;
    pick_instruction();
    repeat (10) begin
      @(negedge CLK);
      check_outputs();
    end
    nRST = 1'b1;
    for (test_idx = 0; test_idx < NUM_TESTS; test_idx++) begin
      if (test_idx == NUM_TESTS / 2) begin  // reset in the middle of the run
        nRST = 1'b0;
        repeat (2) begin
          @(negedge CLK);
          check_outputs();
        end
        nRST = 1'b1;
      end
      run_instruction();
    end
    @(negedge CLK);
    check_outputs();
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * 40 * 10);
    $display("timeout, the run did not finish within %0d cycles", NUM_TESTS * 40);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
